// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     = --timing --assert
TOP       = tb_adv7513_config
FILELIST  = all.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Test passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== all.f ====
hdl/adv7513_pkg.sv
hdl/adv7513_init_rom.sv
hdl/adv7513_sequencer.sv
hdl/i2c_master.sv
hdl/adv7513_config.sv
verification/adv7513_config_assertions.sv
verification/adv7513_i2c_model.sv
verification/tb_adv7513_config.sv

// ==== hdl/adv7513_config.sv ====
`timescale 1ns/1ps

module adv7513_config (
    input  logic       clk,
    input  logic       reset,
    input  logic       hdmi_int,
    input  logic       sda_in,
    output logic       scl_drive_low,
    output logic       sda_drive_low,
    output logic       ready,
    output logic [7:0] pll_error_count
);

    logic [adv7513_pkg::index_width-1:0] index;
    logic [7:0]                          rom_reg_addr;
    logic [7:0]                          rom_value;
    logic                                req;
    logic                                is_read;
    logic [7:0]                          reg_addr;
    logic [7:0]                          wr_data;
    logic                                done;
    logic                                ack_error;
    logic [7:0]                          rd_data;

    adv7513_sequencer u_sequencer (
        .clk             (clk),
        .reset           (reset),
        .hdmi_int        (hdmi_int),
        .index           (index),
        .rom_reg_addr    (rom_reg_addr),
        .rom_value       (rom_value),
        .req             (req),
        .is_read         (is_read),
        .reg_addr        (reg_addr),
        .wr_data         (wr_data),
        .done            (done),
        .ack_error       (ack_error),
        .rd_data         (rd_data),
        .ready           (ready),
        .pll_error_count (pll_error_count)
    );

    adv7513_init_rom u_init_rom (
        .index    (index),
        .reg_addr (rom_reg_addr),
        .value    (rom_value)
    );

    i2c_master u_i2c_master (
        .clk           (clk),
        .reset         (reset),
        .req           (req),
        .is_read       (is_read),
        .reg_addr      (reg_addr),
        .wr_data       (wr_data),
        .sda_in        (sda_in),
        .done          (done),
        .ack_error     (ack_error),
        .rd_data       (rd_data),
        .scl_drive_low (scl_drive_low),
        .sda_drive_low (sda_drive_low)
    );

endmodule

// ==== hdl/adv7513_init_rom.sv ====
`timescale 1ns/1ps

module adv7513_init_rom (
    input  logic [adv7513_pkg::index_width-1:0] index,
    output logic [7:0]                          reg_addr,
    output logic [7:0]                          value
);

    // one entry is {register address, value}
    logic [15:0] entry;

    assign reg_addr = entry[15:8];
    assign value    = entry[7:0];

    always_comb begin
        case (index)
            // all circuits powered up, sync adjustment off
            5'd0:  entry = {8'h41, 8'h10};
            // fixed registers from the programming guide
            5'd1:  entry = {8'h98, 8'h03};
            5'd2:  entry = {8'h9a, 8'he0};
            5'd3:  entry = {8'h9c, 8'h30};
            5'd4:  entry = {8'h9d, 8'h01};
            5'd5:  entry = {8'ha2, 8'ha4};
            5'd6:  entry = {8'ha3, 8'ha4};
            5'd7:  entry = {8'he0, 8'hd0};
            5'd8:  entry = {8'hf9, 8'h00};
            // I2S at 44.1 kHz, 24 bit RGB 4:4:4 input with separate syncs
            5'd9:  entry = {8'h15, 8'h00};
            // sync polarity pass through, 4:3 aspect, DE generator off
            5'd10: entry = {8'h17, 8'h00};
            // 4:4:4 output, 8 bit colour depth
            5'd11: entry = {8'h16, 8'h30};
            5'd12: entry = {8'h55, 8'h00}; // RGB in AVI InfoFrame
            5'd13: entry = {8'h18, 8'h46}; // colour space converter off
            // HDMI mode, HDCP off
            5'd14: entry = {8'haf, 8'h06};
            5'd15: entry = {8'hba, 8'h60};
            // audio from I2S, automatic CTS, MCLK ratio 128 x fs
            5'd16: entry = {8'h0a, 8'h00};
            // N value 0x01880 for 44.1 kHz
            5'd17: entry = {8'h01, 8'h00};
            5'd18: entry = {8'h02, 8'h18};
            5'd19: entry = {8'h03, 8'h80};
            // SPDIF off, MCLK generated inside the chip
            5'd20: entry = {8'h0b, 8'h0e};
            // I2S0 only, right justified, 16 bit samples
            5'd21: entry = {8'h0c, 8'h05};
            5'd22: entry = {8'h0d, 8'h10};
            // HPD and monitor sense interrupts on, then clear any pending
            5'd23: entry = {8'h94, 8'hc0};
            5'd24: entry = {8'h96, 8'hc0};
            // manual VIC unavailable
            5'd25: entry = {8'h3c, 8'h00};
            default: entry = 16'h0000;
        endcase
    end

endmodule

// ==== hdl/adv7513_pkg.sv ====
package adv7513_pkg;

    // 7-bit I2C address of the transmitter without the R/W bit
    localparam logic [6:0] chip_addr = 7'h39;

    // status register holding the PLL lock flag
    localparam logic [7:0] reg_pll_status = 8'h9e;
    localparam int pll_lock_bit = 4;

    // register write table
    localparam int init_len = 26;
    localparam int index_width = 5;
    localparam logic [index_width-1:0] last_index = index_width'(init_len - 1);

    // clock cycles per quarter SCL period kept small for short simulations
    localparam int quarter_bit_clocks = 4;
    localparam int tick_width = $clog2(quarter_bit_clocks);
    localparam logic [tick_width-1:0] tick_max = tick_width'(quarter_bit_clocks - 1);

    // sequencer states
    localparam logic [1:0] seq_issue = 2'd0;
    localparam logic [1:0] seq_wait  = 2'd1;
    localparam logic [1:0] seq_check = 2'd2;
    localparam logic [1:0] seq_idle  = 2'd3;

    // I2C engine states with one per kind of SCL period
    localparam logic [1:0] i2c_idle  = 2'd0;
    localparam logic [1:0] i2c_start = 2'd1;
    localparam logic [1:0] i2c_data  = 2'd2;
    localparam logic [1:0] i2c_stop  = 2'd3;

endpackage

// ==== hdl/adv7513_sequencer.sv ====
`timescale 1ns/1ps

module adv7513_sequencer (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                hdmi_int,
    output logic [adv7513_pkg::index_width-1:0] index,
    input  logic [7:0]                          rom_reg_addr,
    input  logic [7:0]                          rom_value,
    output logic                                req,
    output logic                                is_read,
    output logic [7:0]                          reg_addr,
    output logic [7:0]                          wr_data,
    input  logic                                done,
    input  logic                                ack_error,
    input  logic [7:0]                          rd_data,
    output logic                                ready,
    output logic [7:0]                          pll_error_count
);

    logic [1:0] state;

    always_ff @(posedge clk) begin
        if (!reset) begin
            state           <= adv7513_pkg::seq_issue;
            index           <= '0;
            req             <= 1'b0;
            is_read         <= 1'b0;
            ready           <= 1'b0;
            pll_error_count <= 8'd0;
        end else begin
            // request is a single cycle pulse
            req <= 1'b0;
            case (state)
                adv7513_pkg::seq_issue: begin
                    req     <= 1'b1;
                    is_read <= 1'b0;
                    state   <= adv7513_pkg::seq_wait;
                end
                // lock status read after the last table write
                adv7513_pkg::seq_check: begin
                    req     <= 1'b1;
                    is_read <= 1'b1;
                    state   <= adv7513_pkg::seq_wait;
                end
                adv7513_pkg::seq_wait: begin
                    if (done) begin
                        if (ack_error) begin
                            // same transaction again with the table position kept
                            state <= is_read ? adv7513_pkg::seq_check : adv7513_pkg::seq_issue;
                        end else if (is_read) begin
                            index <= '0;
                            if (rd_data[adv7513_pkg::pll_lock_bit]) begin
                                ready <= 1'b1;
                                state <= adv7513_pkg::seq_idle;
                            end else begin
                                pll_error_count <= pll_error_count + 8'd1;
                                state           <= adv7513_pkg::seq_issue;
                            end
                        end else if (index == adv7513_pkg::last_index) begin
                            state <= adv7513_pkg::seq_check;
                        end else begin
                            index <= index + adv7513_pkg::index_width'(1);
                            state <= adv7513_pkg::seq_issue;
                        end
                    end
                end
                default: begin
                    // interrupt from the chip such as hot plug needs a full rerun
                    if (!hdmi_int) begin
                        ready <= 1'b0;
                        state <= adv7513_pkg::seq_issue;
                    end
                end
            endcase
        end
    end

    // transaction fields latched with the request
    always_ff @(posedge clk) begin
        if (state == adv7513_pkg::seq_issue) begin
            reg_addr <= rom_reg_addr;
            wr_data  <= rom_value;
        end else if (state == adv7513_pkg::seq_check) begin
            reg_addr <= adv7513_pkg::reg_pll_status;
        end
    end

endmodule

// ==== hdl/i2c_master.sv ====
`timescale 1ns/1ps

module i2c_master (
    input  logic       clk,
    input  logic       reset,
    input  logic       req,
    input  logic       is_read,
    input  logic [7:0] reg_addr,
    input  logic [7:0] wr_data,
    input  logic       sda_in,
    output logic       done,
    output logic       ack_error,
    output logic [7:0] rd_data,
    output logic       scl_drive_low,
    output logic       sda_drive_low
);

    logic [1:0]                         state;
    logic [adv7513_pkg::tick_width-1:0] tick_count;
    logic                               tick;
    logic                               period_end;
    logic [1:0]                         quarter;
    logic [3:0]                         bit_count;
    logic [1:0]                         byte_count;
    logic [1:0]                         byte_sel;
    logic [7:0]                         next_byte;
    logic [7:0]                         shift;
    logic                               sda_sample;
    logic                               receiving;
    logic                               scl_low_next;
    logic                               sda_low_next;

    assign tick       = (tick_count == adv7513_pkg::tick_max);
    assign period_end = tick && (quarter == 2'd3);
    // byte 3 only exists in a read and carries the register data
    assign receiving  = (byte_count == 2'd3);

    // byte to load when the next data period starts
    always_comb begin
        byte_sel = (state == adv7513_pkg::i2c_data) ? byte_count + 2'd1 : byte_count;
        case (byte_sel)
            2'd0: next_byte = {adv7513_pkg::chip_addr, 1'b0};
            2'd1: next_byte = reg_addr;
            2'd2: next_byte = is_read ? {adv7513_pkg::chip_addr, 1'b1} : wr_data;
            default: next_byte = 8'hff;
        endcase
    end

    // line levels per quarter with SCL high in quarters 1 and 2
    always_comb begin
        scl_low_next = 1'b0;
        sda_low_next = 1'b0;
        case (state)
            adv7513_pkg::i2c_start: begin
                // repeated start begins with SCL still low
                scl_low_next = (quarter == 2'd3) || (quarter == 2'd0 && byte_count != 2'd0);
                sda_low_next = quarter[1];
            end
            adv7513_pkg::i2c_data: begin
                scl_low_next = (quarter == 2'd0) || (quarter == 2'd3);
                sda_low_next = (bit_count != 4'd8) && !receiving && !shift[7];
            end
            adv7513_pkg::i2c_stop: begin
                scl_low_next = (quarter == 2'd0);
                sda_low_next = !quarter[1];
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            state         <= adv7513_pkg::i2c_idle;
            tick_count    <= '0;
            quarter       <= 2'd0;
            bit_count     <= 4'd0;
            byte_count    <= 2'd0;
            done          <= 1'b0;
            ack_error     <= 1'b0;
            scl_drive_low <= 1'b0;
            sda_drive_low <= 1'b0;
        end else begin
            done          <= 1'b0;
            scl_drive_low <= scl_low_next;
            sda_drive_low <= sda_low_next;
            if (state == adv7513_pkg::i2c_idle) begin
                tick_count <= '0;
                quarter    <= 2'd0;
                if (req) begin
                    byte_count <= 2'd0;
                    ack_error  <= 1'b0;
                    state      <= adv7513_pkg::i2c_start;
                end
            end else begin
                tick_count <= tick ? '0 : tick_count + adv7513_pkg::tick_width'(1);
                if (tick) begin
                    quarter <= quarter + 2'd1;
                end
            end
            if (period_end) begin
                case (state)
                    adv7513_pkg::i2c_start: begin
                        bit_count <= 4'd0;
                        state     <= adv7513_pkg::i2c_data;
                    end
                    adv7513_pkg::i2c_data: begin
                        if (bit_count != 4'd8) begin
                            bit_count <= bit_count + 4'd1;
                        end else if (!receiving && sda_sample) begin
                            // no ACK from the slave
                            ack_error <= 1'b1;
                            state     <= adv7513_pkg::i2c_stop;
                        end else if (receiving || (byte_count == 2'd2 && !is_read)) begin
                            state <= adv7513_pkg::i2c_stop;
                        end else if (byte_count == 2'd1 && is_read) begin
                            byte_count <= 2'd2;
                            state      <= adv7513_pkg::i2c_start;
                        end else begin
                            byte_count <= byte_count + 2'd1;
                            bit_count  <= 4'd0;
                        end
                    end
                    default: begin
                        done  <= 1'b1;
                        state <= adv7513_pkg::i2c_idle;
                    end
                endcase
            end
        end
    end

    // serial data path
    always_ff @(posedge clk) begin
        if (tick && quarter == 2'd2) begin
            sda_sample <= sda_in;
        end
        if (period_end) begin
            if (state == adv7513_pkg::i2c_start) begin
                shift <= next_byte;
            end else if (state == adv7513_pkg::i2c_data) begin
                if (bit_count != 4'd8) begin
                    shift <= {shift[6:0], sda_sample};
                end else if (receiving) begin
                    rd_data <= shift;
                end else begin
                    shift <= next_byte;
                end
            end
        end
    end

endmodule

// ==== verification/adv7513_config_assertions.sv ====
`timescale 1ns/1ps

module adv7513_config_assertions (
    input logic clk,
    input logic reset,
    input logic req,
    input logic done,
    input logic ready
);

    // one transaction in flight between req and done
    logic outstanding;

    always_ff @(posedge clk) begin
        if (!reset) begin
            outstanding <= 1'b0;
        end else if (req) begin
            outstanding <= 1'b1;
        end else if (done) begin
            outstanding <= 1'b0;
        end
    end

    req_while_busy: assert property (@(posedge clk) disable iff (!reset) req |-> !outstanding)
        else $error("request issued while a transaction was outstanding");

    ready_while_busy: assert property (@(posedge clk) disable iff (!reset)
        ready |-> !outstanding)
        else $error("ready high while a transaction was outstanding");

    ready_after_reset: assert property (@(posedge clk) !reset |=> !ready)
        else $error("ready high in the cycle after reset");

endmodule

bind adv7513_sequencer adv7513_config_assertions u_assertions (.*);

// ==== verification/adv7513_i2c_model.sv ====
`timescale 1ns/1ps

module adv7513_i2c_model (
    input  logic scl_drive_low,
    input  logic sda_drive_low,
    input  logic clear,
    input  int   unlocked_reads,
    input  int   nack_index,
    output logic sda_line
);

    // expected register writes as {register, value} in table order
    localparam logic [15:0] expected [26] = '{
        16'h4110, 16'h9803, 16'h9ae0, 16'h9c30, 16'h9d01, 16'ha2a4, 16'ha3a4,
        16'he0d0, 16'hf900, 16'h1500, 16'h1700, 16'h1630, 16'h5500, 16'h1846,
        16'haf06, 16'hba60, 16'h0a00, 16'h0100, 16'h0218, 16'h0380, 16'h0b0e,
        16'h0c05, 16'h0d10, 16'h94c0, 16'h96c0, 16'h3c00
    };

    logic       scl;
    logic       sda;
    logic       sda_low;
    logic       scl_q;
    logic       sda_q;
    logic       rd_mode;
    logic       sending;
    logic [7:0] shift;
    logic [7:0] pointer;
    logic [7:0] tx;
    int         bit_cnt;
    int         byte_num;
    int         write_count;
    int         seq_count;
    int         status_reads;
    int         mismatch_count;
    int         nack_seen;

    // wired-AND of both open-drain drivers pulled up when released
    assign scl      = !scl_drive_low;
    assign sda      = !(sda_drive_low || sda_low);
    assign sda_line = sda;

    // called on the falling SCL edge that opens the ACK slot
    task automatic take_byte();
        logic [15:0] exp_entry;
        exp_entry = expected[write_count % 26];
        if (byte_num == 0) begin
            rd_mode = shift[0];
            sda_low = (shift[7:1] == 7'h39);
            if (rd_mode) begin
                // lock bit stays clear for the first reads while the other bits are set
                tx = (status_reads < unlocked_reads) ? 8'hef : 8'h10;
                status_reads++;
                if (pointer != 8'h9e) begin
                    mismatch_count++;
                end
            end
        end else if (byte_num == 1) begin
            pointer = shift;
            sda_low = 1'b1;
        end else if (write_count % 26 == nack_index && nack_seen == 0) begin
            nack_seen = 1;
            sda_low   = 1'b0;
        end else begin
            sda_low = 1'b1;
            if ({pointer, shift} != exp_entry) begin
                mismatch_count++;
            end
            write_count++;
            if (write_count % 26 == 0) begin
                seq_count++;
            end
        end
    endtask

    initial begin
        scl_q = 1'b1;
        sda_q = 1'b1;
        sda_low = 1'b0;
        rd_mode = 1'b0;
        sending = 1'b0;
        pointer = 8'h00;
        bit_cnt = 0;
        byte_num = 0;
        forever begin
            @(scl or sda or clear);
            if (clear) begin
                write_count    = 0;
                seq_count      = 0;
                status_reads   = 0;
                mismatch_count = 0;
                nack_seen      = 0;
                sda_low        = 1'b0;
                sending        = 1'b0;
                bit_cnt        = 0;
            end else if (scl_q && scl && sda_q != sda) begin
                // START or STOP resets the byte framing
                bit_cnt  = 0;
                byte_num = 0;
                sending  = 1'b0;
                sda_low  = 1'b0;
            end else if (!scl_q && scl) begin
                if (!sending && bit_cnt < 8) begin
                    shift = {shift[6:0], sda};
                end
                bit_cnt++;
            end else if (scl_q && !scl) begin
                if (bit_cnt == 8) begin
                    if (sending) begin
                        sda_low = 1'b0;
                    end else begin
                        take_byte();
                    end
                end else if (bit_cnt == 9) begin
                    bit_cnt = 0;
                    byte_num++;
                    sda_low = 1'b0;
                    if (sending) begin
                        sending = 1'b0;
                    end else if (rd_mode && byte_num == 1) begin
                        sending = 1'b1;
                        sda_low = !tx[7];
                    end
                end else if (sending) begin
                    sda_low = !tx[7 - bit_cnt];
                end
            end
            scl_q = scl;
            sda_q = sda;
        end
    end

endmodule

// ==== verification/tb_adv7513_config.sv ====
`timescale 1ns/1ps

module tb_adv7513_config;

    localparam int rows = 4;
    localparam int max_unlocked = 2;
    localparam int cycle_limit = rows * (max_unlocked + 2) * (adv7513_pkg::init_len + 1)
        * 39 * 4 * adv7513_pkg::quarter_bit_clocks * 2;

    // scenario table with unlocked reads, NACKed write index, interrupt and final error count
    int row_unlocked [rows] = '{0, 2, 0, 1};
    int row_nack     [rows] = '{-1, -1, 5, 25};
    bit row_int      [rows] = '{0, 0, 0, 1};
    int row_count    [rows] = '{0, 2, 0, 1};

    logic       clk;
    logic       reset;
    logic       hdmi_int;
    logic       sda_in;
    logic       scl_drive_low;
    logic       sda_drive_low;
    logic       ready;
    logic [7:0] pll_error_count;
    logic       clear;
    int         unlocked_reads;
    int         nack_index;
    int         error_count;
    int         check_count;
    int         cycles;

    adv7513_config u_adv7513_config (
        .clk             (clk),
        .reset           (reset),
        .hdmi_int        (hdmi_int),
        .sda_in          (sda_in),
        .scl_drive_low   (scl_drive_low),
        .sda_drive_low   (sda_drive_low),
        .ready           (ready),
        .pll_error_count (pll_error_count)
    );

    adv7513_i2c_model u_i2c_model (
        .scl_drive_low  (scl_drive_low),
        .sda_drive_low  (sda_drive_low),
        .clear          (clear),
        .unlocked_reads (unlocked_reads),
        .nack_index     (nack_index),
        .sda_line       (sda_in)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // run limit
    initial begin
        cycles = 0;
        while (cycles <= cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, ready never came", cycles);
        $display("Test failed");
        $finish;
    end

    task automatic check_value(string name, int got, int exp);
        check_count++;
        assert (got == exp) else begin
            $display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic wait_ready();
        while (!ready) @(negedge clk);
    endtask

    task automatic check_model(int seqs);
        check_value("write_count", u_i2c_model.write_count, seqs * adv7513_pkg::init_len);
        check_value("seq_count", u_i2c_model.seq_count, seqs);
        check_value("status_reads", u_i2c_model.status_reads, seqs);
        check_value("mismatch_count", u_i2c_model.mismatch_count, 0);
    endtask

    task automatic run_row(int r);
        @(negedge clk);
        reset = 1'b0;
        clear = 1'b1;
        unlocked_reads = row_unlocked[r];
        nack_index = row_nack[r];
        repeat (2) @(negedge clk);
        reset = 1'b1;
        clear = 1'b0;
        wait_ready();
        check_value("pll_error_count", int'(pll_error_count), row_count[r]);
        check_model(row_unlocked[r] + 1);
        if (row_int[r]) begin
            hdmi_int = 1'b0;
            @(negedge clk);
            hdmi_int = 1'b1;
            check_value("ready", int'(ready), 0);
            wait_ready();
            check_model(row_unlocked[r] + 2);
            check_value("pll_error_count", int'(pll_error_count), row_count[r]);
        end
    endtask

    initial begin
        reset = 1'b0;
        hdmi_int = 1'b1;
        clear = 1'b1;
        unlocked_reads = 0;
        nack_index = -1;
        error_count = 0;
        check_count = 0;
        for (int r = 0; r < rows; r++) begin
            run_row(r);
        end
        $display("errors: %0d of %0d checks", error_count, check_count);
        if (error_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
